// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/alu.sv
module alu
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic [xlen-1:0] alu_a,
    input  logic [xlen-1:0] alu_b,
    input  alu_cmd_t        alu_cmd,
    output logic [xlen-1:0] alu_result,
    output alu_flags_t      alu_flags
);

    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic add_ovf;
    logic sub_ovf;

    assign sum  = alu_a + alu_b;
    assign diff = alu_a - alu_b;

    // signed overflow from operand and result signs
    assign add_ovf = (alu_a[xlen-1] == alu_b[xlen-1]) && (sum[xlen-1] != alu_a[xlen-1]);
    assign sub_ovf = (alu_a[xlen-1] != alu_b[xlen-1]) && (diff[xlen-1] != alu_a[xlen-1]);

    always_comb begin
        case (alu_cmd)
            alu_sub: alu_result = diff;
            alu_and: alu_result = alu_a & alu_b;
            alu_or: alu_result = alu_a | alu_b;
            alu_xor: alu_result = alu_a ^ alu_b;
            // signed less than
            alu_slt: alu_result = {{(xlen-1){1'b0}}, diff[xlen-1] ^ sub_ovf};
            default: alu_result = sum;
        endcase
    end

    assign alu_flags.zero     = (alu_result == '0);
    assign alu_flags.msb      = alu_result[xlen-1];
    assign alu_flags.overflow = (alu_cmd == alu_add) ? add_ovf :
                                (alu_cmd == alu_sub) ? sub_ovf : 1'b0;
    assign alu_flags.spare    = 1'b0;

endmodule

// File: hw/apb_requester.sv
module apb_requester
    import core_cfg_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            mem_req,
    input  logic            mem_write,
    input  logic [xlen-1:0] mem_addr,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] rdata,
    output logic            mem_done,
    output logic            mem_err,
    output logic [xlen-1:0] paddr,
    output logic            psel,
    output logic            penable,
    output logic            pwrite,
    output logic [xlen-1:0] pwdata,
    input  logic [xlen-1:0] prdata,
    input  logic            pready,
    input  logic            pslverr
);

    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_state_t;

    apb_state_t state;

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            state  <= apb_idle;
            pwrite <= 1'b0;
        end else begin
            case (state)
                apb_idle: begin
                    if (mem_req) begin
                        pwrite <= mem_write;
                        state  <= apb_setup;
                    end
                end
                apb_setup: state <= apb_access;
                // access holds until the completer is ready
                default: begin
                    if (pready) begin
                        state <= apb_idle;
                    end
                end
            endcase
        end
    end

    // address and data held from setup to completion
    always_ff @(posedge clk) begin
        if ((state == apb_idle) && mem_req) begin
            paddr  <= mem_addr;
            pwdata <= wdata;
        end
    end

    assign psel     = (state != apb_idle);
    assign penable  = (state == apb_access);
    assign mem_done = penable && pready;
    assign mem_err  = mem_done && pslverr;
    assign rdata    = prdata;

    a_paddr_stable: assert property (@(posedge clk) disable iff (rst_n)
        (psel && !pready) |=> $stable(paddr));

endmodule

// File: hw/control_unit.sv
module control_unit
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [6:0]  opcode,
    input  logic [2:0]  funct3,
    input  logic        funct7_b5,
    input  alu_flags_t  alu_flags,
    input  logic        mem_done,
    input  logic        mem_err,
    output logic        mem_req,
    output logic        mem_write,
    output logic        mem_addr_sel,
    output logic        alu_src,
    output logic        a_src,
    output alu_cmd_t    alu_cmd,
    output logic        rf_we,
    output logic [1:0]  rf_src,
    output logic        pc_we,
    output logic        pc_src,
    output logic        ir_we,
    output logic        mdr_we,
    output logic        halted
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    // request of the current memory state already issued
    logic req_sent;
    logic br_taken;

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            state    <= st_fetch;
            req_sent <= 1'b0;
        end else begin
            state    <= next_state;
            req_sent <= (next_state == state);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_fetch: begin
                if (mem_done) begin
                    next_state = mem_err ? st_halt : st_decode;
                end
            end
            st_decode: begin
                case (opcode)
                    op_rtype, op_addi, op_auipc, op_load, op_store,
                    op_branch, op_jal, op_jalr: next_state = st_execute;
                    // unknown opcode ends the program
                    default: next_state = st_halt;
                endcase
            end
            st_execute: begin
                case (opcode)
                    op_load, op_store: next_state = st_mem;
                    op_branch, op_jal, op_jalr: next_state = st_fetch;
                    default: next_state = st_writeback;
                endcase
            end
            st_mem: begin
                if (mem_done && mem_err) begin
                    next_state = st_halt;
                end else if (mem_done) begin
                    next_state = (opcode == op_load) ? st_writeback : st_fetch;
                end
            end
            st_writeback: next_state = st_fetch;
            default: next_state = st_halt;
        endcase
    end

    // only beq and bne are decoded
    always_comb begin
        case (funct3)
            f3_beq: br_taken = alu_flags.zero;
            f3_bne: br_taken = !alu_flags.zero;
            default: br_taken = 1'b0;
        endcase
    end

    // operand select and alu command follow the opcode in every state
    always_comb begin
        a_src   = 1'b0;
        alu_src = 1'b1;
        alu_cmd = alu_add;
        case (opcode)
            op_rtype: begin
                alu_src = 1'b0;
                case (funct3)
                    f3_add_sub: alu_cmd = funct7_b5 ? alu_sub : alu_add;
                    f3_slt: alu_cmd = alu_slt;
                    f3_xor: alu_cmd = alu_xor;
                    f3_or: alu_cmd = alu_or;
                    f3_and: alu_cmd = alu_and;
                    default: alu_cmd = alu_add;
                endcase
            end
            // compare rs1 against rs2
            op_branch: begin
                alu_src = 1'b0;
                alu_cmd = alu_sub;
            end
            // pc based address
            op_auipc, op_jal: a_src = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        mem_req      = ((state == st_fetch) || (state == st_mem)) && !req_sent;
        mem_write    = (state == st_mem) && (opcode == op_store);
        mem_addr_sel = (state == st_mem);
        rf_we        = 1'b0;
        rf_src       = rf_src_alu;
        pc_we        = 1'b0;
        pc_src       = 1'b0;
        ir_we        = 1'b0;
        mdr_we       = 1'b0;
        case (state)
            st_fetch: ir_we = mem_done && !mem_err;
            st_execute: begin
                if (opcode == op_branch) begin
                    pc_we  = 1'b1;
                    pc_src = br_taken;
                end else if ((opcode == op_jal) || (opcode == op_jalr)) begin
                    // link register gets pc+4
                    rf_we  = 1'b1;
                    rf_src = rf_src_pc4;
                    pc_we  = 1'b1;
                    pc_src = 1'b1;
                end
            end
            st_mem: begin
                mdr_we = mem_done && !mem_err && (opcode == op_load);
                // store retires here
                pc_we  = mem_done && !mem_err && (opcode == op_store);
            end
            st_writeback: begin
                rf_we  = 1'b1;
                rf_src = (opcode == op_load) ? rf_src_mem : rf_src_alu;
                pc_we  = 1'b1;
            end
            default: ;
        endcase
    end

    assign halted = (state == st_halt);

    // requests only come from the memory states
    a_req_state: assert property (@(posedge clk) disable iff (rst_n)
        mem_req |-> (state inside {st_fetch, st_mem}));

    // one request per memory state
    a_req_pulse: assert property (@(posedge clk) disable iff (rst_n)
        mem_req |=> !mem_req);

    a_we_excl: assert property (@(posedge clk) disable iff (rst_n)
        !(rf_we && mem_write));

endmodule

// File: hw/core_cfg_pkg.sv
package core_cfg_pkg;

    // data and address width
    localparam int xlen = 32;
    localparam int reg_count = 32;
    localparam int reg_aw = $clog2(reg_count);

    // first fetch address
    localparam logic [xlen-1:0] reset_pc = '0;

    // register write data select
    localparam logic [1:0] rf_src_alu = 2'd0;
    localparam logic [1:0] rf_src_mem = 2'd1;
    localparam logic [1:0] rf_src_pc4 = 2'd2;

    typedef enum logic [3:0] {
        st_fetch     = 4'd0,
        st_decode    = 4'd1,
        st_execute   = 4'd2,
        st_mem       = 4'd3,
        st_writeback = 4'd4,
        st_halt      = 4'd5
    } ctrl_state_t;

endpackage

// File: hw/datapath.sv
module datapath
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_addr_sel,
    input  logic              alu_src,
    input  logic              a_src,
    input  logic [1:0]        rf_src,
    input  logic              pc_we,
    input  logic              pc_src,
    input  logic              ir_we,
    input  logic              mdr_we,
    input  logic [xlen-1:0]   rdata,
    input  logic [xlen-1:0]   alu_result,
    input  logic [xlen-1:0]   rs1_data,
    input  logic [xlen-1:0]   rs2_data,
    output logic [6:0]        opcode,
    output logic [2:0]        funct3,
    output logic              funct7_b5,
    output logic [reg_aw-1:0] rs1_addr,
    output logic [reg_aw-1:0] rs2_addr,
    output logic [reg_aw-1:0] rd_addr,
    output logic [xlen-1:0]   rf_wdata,
    output logic [xlen-1:0]   alu_a,
    output logic [xlen-1:0]   alu_b,
    output logic [xlen-1:0]   mem_addr,
    output logic [xlen-1:0]   wdata
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] ir;
    logic [xlen-1:0] mdr;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] target;

    // pc holds the current instruction until it retires
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            pc <= reset_pc;
        end else if (pc_we) begin
            pc <= pc_src ? target : pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_we) begin
            ir <= rdata;
        end
        if (mdr_we) begin
            mdr <= rdata;
        end
    end

    // instruction fields
    assign opcode    = ir[6:0];
    assign rd_addr   = ir[11:7];
    assign funct3    = ir[14:12];
    assign rs1_addr  = ir[19:15];
    assign rs2_addr  = ir[24:20];
    assign funct7_b5 = ir[30];

    // immediate format picked by opcode
    always_comb begin
        case (opcode)
            op_store: imm = {{(xlen-12){ir[31]}}, ir[31:25], ir[11:7]};
            op_branch: imm = {{(xlen-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            op_auipc: imm = {ir[31:12], 12'b0};
            op_jal: imm = {{(xlen-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            default: imm = {{(xlen-12){ir[31]}}, ir[31:20]};
        endcase
    end

    assign pc_plus4 = pc + xlen'(4);

    // branches use their own adder since the alu is busy comparing
    // jump targets come from the alu with bit 0 cleared
    assign target = (opcode == op_branch) ? pc + imm : {alu_result[xlen-1:1], 1'b0};

    assign alu_a    = a_src ? pc : rs1_data;
    assign alu_b    = alu_src ? imm : rs2_data;
    assign mem_addr = mem_addr_sel ? alu_result : pc;
    assign wdata    = rs2_data;

    always_comb begin
        case (rf_src)
            rf_src_mem: rf_wdata = mdr;
            rf_src_pc4: rf_wdata = pc_plus4;
            default: rf_wdata = alu_result;
        endcase
    end

endmodule

// File: hw/reg_file.sv
module reg_file
    import core_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [reg_aw-1:0] rs1_addr,
    input  logic [reg_aw-1:0] rs2_addr,
    input  logic [reg_aw-1:0] rd_addr,
    input  logic [xlen-1:0]   rf_wdata,
    input  logic              rf_we,
    output logic [xlen-1:0]   rs1_data,
    output logic [xlen-1:0]   rs2_data
);

    logic [xlen-1:0] regs [reg_count];

    // no writes while reset is held
    // x0 is never written
    always_ff @(posedge clk) begin
        if (rf_we && !rst_n && (rd_addr != '0)) begin
            regs[rd_addr] <= rf_wdata;
        end
    end

    // async reads, x0 forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: hw/rv_core_top.sv
module rv_core_top
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    output logic [xlen-1:0] paddr,
    output logic            psel,
    output logic            penable,
    output logic            pwrite,
    output logic [xlen-1:0] pwdata,
    input  logic [xlen-1:0] prdata,
    input  logic            pready,
    input  logic            pslverr,
    output logic            halted
);

    // decoded fields back to the FSM
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              funct7_b5;
    alu_flags_t        alu_flags;

    // memory request and completion
    logic              mem_req;
    logic              mem_write;
    logic              mem_done;
    logic              mem_err;
    logic [xlen-1:0]   mem_addr;
    logic [xlen-1:0]   wdata;
    logic [xlen-1:0]   rdata;

    // datapath controls
    logic              mem_addr_sel;
    logic              alu_src;
    logic              a_src;
    alu_cmd_t          alu_cmd;
    logic              rf_we;
    logic [1:0]        rf_src;
    logic              pc_we;
    logic              pc_src;
    logic              ir_we;
    logic              mdr_we;

    // register file and alu
    logic [reg_aw-1:0] rs1_addr;
    logic [reg_aw-1:0] rs2_addr;
    logic [reg_aw-1:0] rd_addr;
    logic [xlen-1:0]   rf_wdata;
    logic [xlen-1:0]   rs1_data;
    logic [xlen-1:0]   rs2_data;
    logic [xlen-1:0]   alu_a;
    logic [xlen-1:0]   alu_b;
    logic [xlen-1:0]   alu_result;

    control_unit control_unit_i (.*);

    datapath datapath_i (.*);

    reg_file reg_file_i (.*);

    alu alu_i (.*);

    // single APB port for fetch and data
    apb_requester apb_requester_i (.*);

endmodule

// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // base opcodes of the supported subset
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_addi   = 7'b0010011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    // funct3 of the r-type alu ops
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 of the branches
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5
    } alu_cmd_t;

    // zero sits in bit 0
    typedef struct packed {
        logic spare;
        logic overflow;
        logic msb;
        logic zero;
    } alu_flags_t;

endpackage

// File: tb.f
hw/rv_isa_pkg.sv
hw/core_cfg_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/datapath.sv
hw/control_unit.sv
hw/apb_requester.sv
hw/rv_core_top.sv
testbench/tb_core.sv

// File: testbench/core_patterns.hex
// program image from @000, data word for lw at @03c
// expected stores from @040, one per line as address then data, closed by ffffffff
// wait-state limit at @07f
@000
ff900093 // addi x1, x0, -7
00c00113 // addi x2, x0, 12
002081b3 // add  x3, x1, x2
10302023 // sw   x3, 0x100(x0)
40208233 // sub  x4, x1, x2
10402223 // sw   x4, 0x104(x0)
0020f2b3 // and  x5, x1, x2
10502423 // sw   x5, 0x108(x0)
0020e333 // or   x6, x1, x2
10602623 // sw   x6, 0x10c(x0)
0020c3b3 // xor  x7, x1, x2
10702823 // sw   x7, 0x110(x0)
0020a433 // slt  x8, x1, x2
10802a23 // sw   x8, 0x114(x0)
0f002483 // lw   x9, 0xf0(x0)
00248533 // add  x10, x9, x2
10a02c23 // sw   x10, 0x118(x0)
00208463 // beq  x1, x2, +8 not taken
10302e23 // sw   x3, 0x11c(x0)
00210463 // beq  x2, x2, +8 taken
12402023 // sw   x4, 0x120(x0) skipped
00211463 // bne  x2, x2, +8 not taken
12502223 // sw   x5, 0x124(x0)
00209463 // bne  x1, x2, +8 taken
12602423 // sw   x6, 0x128(x0) skipped
008005ef // jal  x11, +8
12702623 // sw   x7, 0x12c(x0) skipped
12b02823 // sw   x11, 0x130(x0)
07c00667 // jalr x12, 0x7c(x0)
12802a23 // sw   x8, 0x134(x0) skipped
12802c23 // sw   x8, 0x138(x0) skipped
12c02e23 // sw   x12, 0x13c(x0)
00001697 // auipc x13, 0x1
14d02023 // sw   x13, 0x140(x0)
ffffffff // illegal opcode
@03c
12345678
@040
00000100 00000005 // add
00000104 ffffffed // sub
00000108 00000008 // and
0000010c fffffffd // or
00000110 fffffff5 // xor
00000114 00000001 // slt
00000118 12345684 // lw plus x2
0000011c 00000005 // beq not taken
00000124 00000008 // bne not taken
00000130 00000068 // jal link
0000013c 00000074 // jalr link
00000140 00001080 // auipc
ffffffff
@07f
00000003

// File: testbench/tb_core.sv
module tb_core
    import core_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 10;
    // pattern file layout in words
    localparam int image_words  = 64;
    localparam int list_base    = 64;
    localparam int limit_idx    = 127;
    localparam int mem_words    = 256;
    // quiet cycles watched after halt
    localparam int halt_window  = 20;

    logic            clk;
    logic            rst_n;
    logic [xlen-1:0] paddr;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [xlen-1:0] pwdata;
    logic [xlen-1:0] prdata;
    logic            pready;
    logic            pslverr;
    logic            halted;

    logic [31:0]     pattern [128];
    logic [xlen-1:0] mem [mem_words];
    logic [xlen-1:0] exp_addr [$];
    logic [xlen-1:0] exp_data [$];
    logic [31:0]     lfsr_state;
    logic            loaded = 1'b0;
    logic            halt_seen = 1'b0;
    logic            first_access = 1'b1;
    int              wait_limit = 0;
    int              instr_count = 0;
    int              wait_left = 0;
    int              waits = 0;
    int              write_count = 0;
    int              error_count = 0;
    int              test_count = 0;
    int              failed_count = 0;

    rv_core_top rv_core_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // four fresh bits folded into 0..wait_limit
    task automatic draw_wait(output int w);
        logic [3:0] bits;
        for (int b = 0; b < 4; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[b] = lfsr_state[0];
        end
        w = int'(bits) % (wait_limit + 1);
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s expected %b actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s ok", name);
        end else begin
            failed_count++;
            $display("test %s failed", name);
        end
    endtask

    // one completed APB write against the next expected store
    task automatic record_write();
        int    errors_before;
        string name;
        errors_before = error_count;
        name = $sformatf("store_%0d", write_count);
        if (write_count < exp_addr.size()) begin
            check_word({name, "_addr"}, exp_addr[write_count], paddr);
            check_word({name, "_data"}, exp_data[write_count], pwdata);
        end else begin
            $display("%s is a write beyond the end of the expected list", name);
            error_count++;
        end
        report_test(name, errors_before);
        mem[paddr[9:2]] = pwdata;
        write_count++;
    endtask

    // APB completer with random wait states
    initial begin
        int errors_before;
        pready  <= 1'b0;
        prdata  <= '0;
        pslverr <= 1'b0;
        lfsr_state = 32'h79f1_bf3d;
        for (int i = 0; i < 128; i++) begin
            pattern[i] = '0;
        end
        $readmemh("testbench/core_patterns.hex", pattern);
        // fill tied to the full word address
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'h5a00_0000 ^ (32'(i) << 2);
        end
        for (int i = 0; i < image_words; i++) begin
            if (pattern[i] != '0) begin
                mem[i] = pattern[i];
                instr_count++;
            end
        end
        // address and data pairs up to the sentinel
        for (int k = list_base; k + 1 < limit_idx; k += 2) begin
            if (pattern[k] == 32'hffff_ffff) begin
                break;
            end
            exp_addr.push_back(pattern[k]);
            exp_data.push_back(pattern[k + 1]);
        end
        wait_limit = pattern[limit_idx];
        loaded = 1'b1;
        forever begin
            @(posedge clk);
            if (psel && !penable) begin
                // setup phase
                if (halt_seen) begin
                    $display("an APB transfer started after the core halted");
                    error_count++;
                end
                if (first_access) begin
                    errors_before = error_count;
                    check_word("first_fetch_addr", reset_pc, paddr);
                    check_flag("first_fetch_read", 1'b0, pwrite);
                    report_test("first_fetch", errors_before);
                    first_access = 1'b0;
                end
                draw_wait(waits);
                wait_left = waits;
                if (waits == 0) begin
                    pready <= 1'b1;
                    prdata <= mem[paddr[9:2]];
                end
            end else if (psel && penable && !pready) begin
                if (wait_left <= 1) begin
                    pready <= 1'b1;
                    prdata <= mem[paddr[9:2]];
                end else begin
                    wait_left--;
                end
            end else if (psel && penable && pready) begin
                // access completes on this edge
                pready <= 1'b0;
                if (pwrite) begin
                    record_write();
                end
            end
        end
    end

    initial begin
        int errors_before;
        rst_n <= 1'b1;
        wait (loaded === 1'b1);
        repeat (reset_cycles) @(posedge clk);
        errors_before = error_count;
        check_flag("reset_psel", 1'b0, psel);
        check_flag("reset_penable", 1'b0, penable);
        check_flag("reset_pwrite", 1'b0, pwrite);
        check_flag("reset_halted", 1'b0, halted);
        report_test("reset_state", errors_before);
        rst_n <= 1'b0;
        wait (halted === 1'b1);
        halt_seen = 1'b1;
        errors_before = error_count;
        repeat (halt_window) @(posedge clk);
        check_flag("halted", 1'b1, halted);
        check_flag("halt_psel", 1'b0, psel);
        check_word("write_count", xlen'(exp_addr.size()), xlen'(write_count));
        report_test("halt", errors_before);
        $display("%0d tests, %0d failed, %0d errors, %0d writes",
                 test_count, failed_count, error_count, write_count);
        if ((failed_count == 0) && (error_count == 0)) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // budget per program word scales with the wait limit
    initial begin
        int limit_cycles;
        wait (loaded === 1'b1);
        limit_cycles = reset_cycles + halt_window + instr_count * (6 + wait_limit) * 2;
        repeat (limit_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the program did not halt", limit_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
